// ==== common/simt_irq_pkg.sv ====
/*
 * shared definitions for the SIMT interrupt path
 * controller state encoding, AXI4-Lite channel payloads and register offsets,
 * the status register layout and the interrupt context record
 */
package simt_irq_pkg;

	// PCs and the AXI4-Lite data bus share one width
	localparam int xlen = 32;
	localparam int axil_addr_w = 4;
	localparam int axil_strb_w = xlen / 8;

	// every access is answered with OKAY
	localparam logic [1:0] axil_okay = 2'b00;

	// byte offsets of the control registers
	localparam logic [axil_addr_w-1:0] reg_target = 4'h0;
	localparam logic [axil_addr_w-1:0] reg_isr_pc = 4'h4;
	localparam logic [axil_addr_w-1:0] reg_ctrl = 4'h8;
	localparam logic [axil_addr_w-1:0] reg_status = 4'hC;

	// interrupt controller states, in the order they are visited
	typedef enum logic [2:0] {
		irqc_idle = 3'd0,
		irqc_wait = 3'd1,
		irqc_pc_swap = 3'd2,
		irqc_wait_isr = 3'd3,
		irqc_revert_warp = 3'd4
	} irqc_state_t;

	// AXI4-Lite channel payloads, each carrying its own valid
	typedef struct packed {
		logic valid;
		logic [axil_addr_w-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] data;
		logic [axil_strb_w-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic valid;
		logic [axil_addr_w-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] data;
		logic [1:0] resp;
	} axil_r_t;

	typedef struct packed {
		logic valid;
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic aw;
		logic w;
		logic ar;
		logic r;
		logic b;
	} axil_ready_t;

	// status register, busy sits in bit 0
	typedef struct packed {
		logic not_found;
		logic done;
		logic busy;
	} irq_status_t;

	// target selection as written to TARGET (wid in the upper half, tid in the lower)
	// together with the ISR entry and the PC saved at swap time
	typedef struct packed {
		logic [15:0] wid;
		logic [15:0] tid;
		logic [xlen-1:0] isr_pc;
		logic [xlen-1:0] saved_pc;
	} irq_ctx_t;

endpackage

// ==== hdl/irq_controller.sv ====
/*
 * interrupt controller
 * AXI4-Lite slave holding the target, ISR PC, control and status registers,
 * and the state machine that saves and restores the interrupted warp context
 */
`timescale 1ns/1ps

module irq_controller #(
	parameter int warp_cnt = 4,
	parameter int thread_cnt = 8
) (
	input logic clk,
	input logic reset,
	input simt_irq_pkg::axil_aw_t aw,
	input simt_irq_pkg::axil_w_t w,
	input simt_irq_pkg::axil_ar_t ar,
	input logic bready,
	input logic rready,
	input logic pipeline_drained,
	input logic thread_found,
	input logic isr_done,
	input logic [simt_irq_pkg::xlen-1:0] current_pc,
	input logic [thread_cnt-1:0] current_tmask,
	input logic [warp_cnt-1:0] current_active_warps,
	output simt_irq_pkg::axil_r_t r,
	output simt_irq_pkg::axil_b_t b,
	output simt_irq_pkg::axil_ready_t ready,
	output simt_irq_pkg::irqc_state_t state,
	output logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] wid,
	output logic [((thread_cnt > 1) ? $clog2(thread_cnt) : 1)-1:0] tid,
	output logic [simt_irq_pkg::xlen-1:0] load_pc,
	output logic [thread_cnt-1:0] load_tmask,
	output logic [warp_cnt-1:0] load_wmask
);

	localparam int wid_w = (warp_cnt > 1) ? $clog2(warp_cnt) : 1;
	localparam int tid_w = (thread_cnt > 1) ? $clog2(thread_cnt) : 1;

	simt_irq_pkg::irq_ctx_t ctx;
	simt_irq_pkg::irq_status_t status;
	logic awready_q;
	logic arready_q;
	logic bvalid_q;
	logic rvalid_q;
	logic [simt_irq_pkg::xlen-1:0] rdata_q;
	logic bus_idle;
	logic wr_fire;
	logic rd_fire;
	logic start_req;

	// byte lanes of a write replace only the lanes that are strobed
	function automatic logic [simt_irq_pkg::xlen-1:0] merge_strb(
		input logic [simt_irq_pkg::xlen-1:0] cur,
		input logic [simt_irq_pkg::xlen-1:0] data,
		input logic [simt_irq_pkg::axil_strb_w-1:0] strb
	);
		logic [simt_irq_pkg::xlen-1:0] res;
		res = cur;
		for (int i = 0; i < simt_irq_pkg::axil_strb_w; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	// one transaction at a time, a pending response blocks the next request
	assign bus_idle = !awready_q && !arready_q && !bvalid_q && !rvalid_q;
	assign wr_fire = awready_q && aw.valid && w.valid;
	assign rd_fire = arready_q && ar.valid;
	assign start_req = wr_fire && (aw.addr == simt_irq_pkg::reg_ctrl) && w.strb[0] && w.data[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			awready_q <= 1'b0;
			arready_q <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			// aw and w are accepted together, and a write wins over a read
			awready_q <= bus_idle && aw.valid && w.valid;
			arready_q <= bus_idle && ar.valid && !(aw.valid && w.valid);
			if (wr_fire)
				bvalid_q <= 1'b1;
			else if (bready)
				bvalid_q <= 1'b0;
			if (rd_fire)
				rvalid_q <= 1'b1;
			else if (rready)
				rvalid_q <= 1'b0;
		end
	end

	// read data is latched on the address handshake
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata_q <= '0;
			case (ar.addr)
				simt_irq_pkg::reg_target: rdata_q <= {ctx.wid, ctx.tid};
				simt_irq_pkg::reg_isr_pc: rdata_q <= ctx.isr_pc;
				simt_irq_pkg::reg_status: rdata_q[2:0] <= status;
				default: rdata_q <= '0;
			endcase
		end
	end

	always_comb begin
		b.valid = bvalid_q;
		b.resp = simt_irq_pkg::axil_okay;
		r.valid = rvalid_q;
		r.data = rdata_q;
		r.resp = simt_irq_pkg::axil_okay;
		ready.aw = awready_q;
		ready.w = awready_q;
		ready.ar = arready_q;
		// the r and b ready bits belong to the master and stay low here
		ready.r = 1'b0;
		ready.b = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= simt_irq_pkg::irqc_idle;
			status <= '0;
			ctx <= '0;
		end else begin
			case (state)
				simt_irq_pkg::irqc_idle: begin
					// the target and ISR entry only change while no interrupt is in flight
					if (wr_fire && aw.addr == simt_irq_pkg::reg_target)
						{ctx.wid, ctx.tid} <= merge_strb({ctx.wid, ctx.tid}, w.data, w.strb);
					if (wr_fire && aw.addr == simt_irq_pkg::reg_isr_pc)
						ctx.isr_pc <= merge_strb(ctx.isr_pc, w.data, w.strb);
					if (start_req) begin
						state <= simt_irq_pkg::irqc_wait;
						status <= '{not_found: 1'b0, done: 1'b0, busy: 1'b1};
					end
				end
				simt_irq_pkg::irqc_wait: begin
					// a drained pipeline without the thread aborts the request
					if (pipeline_drained && thread_found) begin
						state <= simt_irq_pkg::irqc_pc_swap;
					end else if (pipeline_drained) begin
						state <= simt_irq_pkg::irqc_idle;
						status <= '{not_found: 1'b1, done: 1'b0, busy: 1'b0};
					end
				end
				simt_irq_pkg::irqc_pc_swap: begin
					ctx.saved_pc <= current_pc;
					state <= simt_irq_pkg::irqc_wait_isr;
				end
				simt_irq_pkg::irqc_wait_isr: begin
					if (isr_done)
						state <= simt_irq_pkg::irqc_revert_warp;
				end
				simt_irq_pkg::irqc_revert_warp: begin
					state <= simt_irq_pkg::irqc_idle;
					status <= '{not_found: 1'b0, done: 1'b1, busy: 1'b0};
				end
				default: state <= simt_irq_pkg::irqc_idle;
			endcase
		end
	end

	// masks of the interrupted warp, taken while the warp table still holds them
	always_ff @(posedge clk) begin
		if (state == simt_irq_pkg::irqc_pc_swap) begin
			load_tmask <= current_tmask;
			load_wmask <= current_active_warps;
		end
	end

	assign wid = ctx.wid[wid_w-1:0];
	assign tid = ctx.tid[tid_w-1:0];
	// ISR entry on the way in, the interrupted PC on the way back
	assign load_pc = (state == simt_irq_pkg::irqc_revert_warp) ? ctx.saved_pc : ctx.isr_pc;

endmodule

// ==== hdl/thread_transfer_unit.sv ====
/*
 * thread transfer unit
 * maps the interrupt controller state onto scheduler pause and load controls,
 * reports drain, thread presence and ISR completion, and records pulled threads
 */
`timescale 1ns/1ps

module thread_transfer_unit #(
	parameter int warp_cnt = 4,
	parameter int thread_cnt = 8
) (
	input logic clk,
	input logic reset,
	input simt_irq_pkg::irqc_state_t state,
	input logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] wid,
	input logic [((thread_cnt > 1) ? $clog2(thread_cnt) : 1)-1:0] tid,
	input logic [simt_irq_pkg::xlen-1:0] load_pc,
	input logic [thread_cnt-1:0] saved_tmask,
	input logic [warp_cnt-1:0] saved_wmask,
	input logic no_pending_instr,
	input logic [warp_cnt-1:0] barrier_stalls,
	input logic [warp_cnt-1:0] ipdom_stack_empty,
	input logic [warp_cnt-1:0][thread_cnt-1:0] thread_masks,
	input logic [warp_cnt-1:0] active_warps,
	input logic [warp_cnt-1:0][simt_irq_pkg::xlen-1:0] warp_pcs,
	input logic branch_valid,
	input logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] branch_wid,
	input logic branch_taken,
	input logic [simt_irq_pkg::xlen-1:0] branch_dest,
	output logic pipeline_drained,
	output logic thread_found,
	output logic isr_done,
	output logic [simt_irq_pkg::xlen-1:0] current_pc,
	output logic [thread_cnt-1:0] current_tmask,
	output logic [warp_cnt-1:0] current_active_warps,
	output logic paused,
	output logic swap_schedule_data,
	output logic [simt_irq_pkg::xlen-1:0] sched_load_pc,
	output logic [thread_cnt-1:0] load_tmask,
	output logic [warp_cnt-1:0] load_wmask,
	output logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] load_wid,
	output logic [warp_cnt-1:0][thread_cnt-1:0] ttu_tid_mask
);

	logic [thread_cnt-1:0] tid_onehot;
	logic [warp_cnt-1:0] wid_onehot;
	logic [thread_cnt-1:0] restored_tmask;
	logic drain_ok;
	logic jump_valid;

	assign tid_onehot = thread_cnt'(1) << tid;
	assign wid_onehot = warp_cnt'(1) << wid;

	// nothing in flight, no warp at a barrier, and the target's divergence stack unwound
	assign drain_ok = no_pending_instr && !(|barrier_stalls) && ipdom_stack_empty[wid];

	// the ISR ends by jumping back to its own entry point
	assign jump_valid = branch_valid && branch_taken && (branch_wid == wid) &&
		(branch_dest == load_pc);

	// the pulled thread leaves the warp, and an emptied warp is switched off
	assign restored_tmask = saved_tmask & ~tid_onehot;

	// status back to the controller
	always_comb begin
		pipeline_drained = 1'b1;
		thread_found = 1'b1;
		isr_done = 1'b0;
		current_pc = '0;
		current_tmask = '0;
		current_active_warps = '0;
		case (state)
			simt_irq_pkg::irqc_wait, simt_irq_pkg::irqc_pc_swap: begin
				if (state == simt_irq_pkg::irqc_wait) begin
					pipeline_drained = drain_ok;
					// a thread already handed over counts as absent
					thread_found = active_warps[wid] && thread_masks[wid][tid] &&
						ttu_tid_mask[wid][tid];
				end
				current_pc = warp_pcs[wid];
				current_tmask = thread_masks[wid];
				current_active_warps = active_warps;
			end
			simt_irq_pkg::irqc_wait_isr: isr_done = jump_valid;
			simt_irq_pkg::irqc_revert_warp: isr_done = 1'b1;
			default: begin
				pipeline_drained = 1'b0;
				thread_found = 1'b0;
			end
		endcase
	end

	// scheduler controls
	always_comb begin
		paused = 1'b0;
		swap_schedule_data = 1'b0;
		sched_load_pc = load_pc;
		load_tmask = '0;
		load_wmask = '0;
		load_wid = wid;
		case (state)
			// stop issuing as soon as the pipeline is quiet
			simt_irq_pkg::irqc_wait: paused = drain_ok;
			simt_irq_pkg::irqc_pc_swap: begin
				paused = 1'b1;
				swap_schedule_data = 1'b1;
				load_tmask = tid_onehot;
				load_wmask = wid_onehot;
			end
			simt_irq_pkg::irqc_revert_warp: begin
				paused = 1'b1;
				swap_schedule_data = 1'b1;
				load_tmask = restored_tmask;
				load_wmask = (|restored_tmask) ? saved_wmask : (saved_wmask & ~wid_onehot);
			end
			default: paused = 1'b0;
		endcase
	end

	// cleared bits mark threads now owned by the scalar core
	always_ff @(posedge clk) begin
		if (reset)
			ttu_tid_mask <= '1;
		else if (state == simt_irq_pkg::irqc_revert_warp)
			ttu_tid_mask[wid][tid] <= 1'b0;
	end

endmodule

// ==== hdl/warp_table.sv ====
/*
 * warp table
 * per-warp PC and thread mask with the active-warp vector,
 * advanced by issue and taken branches and overwritten by transfer unit loads
 */
`timescale 1ns/1ps

module warp_table #(
	parameter int warp_cnt = 4,
	parameter int thread_cnt = 8
) (
	input logic clk,
	input logic reset,
	input logic paused,
	input logic issue_valid,
	input logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] issue_wid,
	input logic branch_valid,
	input logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] branch_wid,
	input logic branch_taken,
	input logic [simt_irq_pkg::xlen-1:0] branch_dest,
	input logic swap_schedule_data,
	input logic [simt_irq_pkg::xlen-1:0] load_pc,
	input logic [thread_cnt-1:0] load_tmask,
	input logic [warp_cnt-1:0] load_wmask,
	input logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] load_wid,
	output logic [warp_cnt-1:0][simt_irq_pkg::xlen-1:0] warp_pcs,
	output logic [warp_cnt-1:0][thread_cnt-1:0] thread_masks,
	output logic [warp_cnt-1:0] active_warps
);

	localparam int wid_w = (warp_cnt > 1) ? $clog2(warp_cnt) : 1;

	always_ff @(posedge clk) begin
		if (reset) begin
			// every warp starts at PC 0 with all of its threads running
			warp_pcs <= '0;
			thread_masks <= '1;
			active_warps <= '1;
		end else begin
			for (int i = 0; i < warp_cnt; i++) begin
				// a load beats a branch, and a branch beats sequential issue
				if (swap_schedule_data && load_wid == wid_w'(i)) begin
					warp_pcs[i] <= load_pc;
					thread_masks[i] <= load_tmask;
				end else if (branch_valid && branch_taken && branch_wid == wid_w'(i)) begin
					warp_pcs[i] <= branch_dest;
				end else if (issue_valid && !paused && issue_wid == wid_w'(i)) begin
					warp_pcs[i] <= warp_pcs[i] + simt_irq_pkg::xlen'(4);
				end
			end
			// the transfer unit hands over the complete active vector
			if (swap_schedule_data)
				active_warps <= load_wmask;
		end
	end

endmodule

// ==== hdl/simt_irq_top.sv ====
/*
 * top level of the SIMT interrupt path
 * connects the interrupt controller, the thread transfer unit and the warp table
 */
`timescale 1ns/1ps

module simt_irq_top #(
	parameter int warp_cnt = 4,
	parameter int thread_cnt = 8
) (
	input logic clk,
	input logic reset,
	input simt_irq_pkg::axil_aw_t aw,
	input simt_irq_pkg::axil_w_t w,
	input simt_irq_pkg::axil_ar_t ar,
	input logic bready,
	input logic rready,
	input logic no_pending_instr,
	input logic [warp_cnt-1:0] barrier_stalls,
	input logic [warp_cnt-1:0] ipdom_stack_empty,
	input logic issue_valid,
	input logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] issue_wid,
	input logic branch_valid,
	input logic [((warp_cnt > 1) ? $clog2(warp_cnt) : 1)-1:0] branch_wid,
	input logic branch_taken,
	input logic [simt_irq_pkg::xlen-1:0] branch_dest,
	output simt_irq_pkg::axil_r_t r,
	output simt_irq_pkg::axil_b_t b,
	output simt_irq_pkg::axil_ready_t ready,
	output logic [warp_cnt-1:0][simt_irq_pkg::xlen-1:0] warp_pcs,
	output logic [warp_cnt-1:0][thread_cnt-1:0] thread_masks,
	output logic [warp_cnt-1:0] active_warps,
	output logic [warp_cnt-1:0][thread_cnt-1:0] ttu_tid_mask,
	output logic paused
);

	localparam int wid_w = (warp_cnt > 1) ? $clog2(warp_cnt) : 1;
	localparam int tid_w = (thread_cnt > 1) ? $clog2(thread_cnt) : 1;

	// controller to transfer unit
	simt_irq_pkg::irqc_state_t irqc_state;
	logic [wid_w-1:0] tgt_wid;
	logic [tid_w-1:0] tgt_tid;
	logic [simt_irq_pkg::xlen-1:0] irq_load_pc;
	logic [thread_cnt-1:0] saved_tmask;
	logic [warp_cnt-1:0] saved_wmask;

	// transfer unit back to the controller
	logic pipeline_drained;
	logic thread_found;
	logic isr_done;
	logic [simt_irq_pkg::xlen-1:0] current_pc;
	logic [thread_cnt-1:0] current_tmask;
	logic [warp_cnt-1:0] current_active_warps;

	// transfer unit to the warp table
	logic swap_schedule_data;
	logic [simt_irq_pkg::xlen-1:0] sched_load_pc;
	logic [thread_cnt-1:0] load_tmask;
	logic [warp_cnt-1:0] load_wmask;
	logic [wid_w-1:0] load_wid;

	irq_controller #(
		.warp_cnt(warp_cnt),
		.thread_cnt(thread_cnt)
	) u_irq_controller (
		.clk(clk),
		.reset(reset),
		.aw(aw),
		.w(w),
		.ar(ar),
		.bready(bready),
		.rready(rready),
		.pipeline_drained(pipeline_drained),
		.thread_found(thread_found),
		.isr_done(isr_done),
		.current_pc(current_pc),
		.current_tmask(current_tmask),
		.current_active_warps(current_active_warps),
		.r(r),
		.b(b),
		.ready(ready),
		.state(irqc_state),
		.wid(tgt_wid),
		.tid(tgt_tid),
		.load_pc(irq_load_pc),
		.load_tmask(saved_tmask),
		.load_wmask(saved_wmask)
	);

	thread_transfer_unit #(
		.warp_cnt(warp_cnt),
		.thread_cnt(thread_cnt)
	) u_thread_transfer_unit (
		.clk(clk),
		.reset(reset),
		.state(irqc_state),
		.wid(tgt_wid),
		.tid(tgt_tid),
		.load_pc(irq_load_pc),
		.saved_tmask(saved_tmask),
		.saved_wmask(saved_wmask),
		.no_pending_instr(no_pending_instr),
		.barrier_stalls(barrier_stalls),
		.ipdom_stack_empty(ipdom_stack_empty),
		.thread_masks(thread_masks),
		.active_warps(active_warps),
		.warp_pcs(warp_pcs),
		.branch_valid(branch_valid),
		.branch_wid(branch_wid),
		.branch_taken(branch_taken),
		.branch_dest(branch_dest),
		.pipeline_drained(pipeline_drained),
		.thread_found(thread_found),
		.isr_done(isr_done),
		.current_pc(current_pc),
		.current_tmask(current_tmask),
		.current_active_warps(current_active_warps),
		.paused(paused),
		.swap_schedule_data(swap_schedule_data),
		.sched_load_pc(sched_load_pc),
		.load_tmask(load_tmask),
		.load_wmask(load_wmask),
		.load_wid(load_wid),
		.ttu_tid_mask(ttu_tid_mask)
	);

	warp_table #(
		.warp_cnt(warp_cnt),
		.thread_cnt(thread_cnt)
	) u_warp_table (
		.clk(clk),
		.reset(reset),
		.paused(paused),
		.issue_valid(issue_valid),
		.issue_wid(issue_wid),
		.branch_valid(branch_valid),
		.branch_wid(branch_wid),
		.branch_taken(branch_taken),
		.branch_dest(branch_dest),
		.swap_schedule_data(swap_schedule_data),
		.load_pc(sched_load_pc),
		.load_tmask(load_tmask),
		.load_wmask(load_wmask),
		.load_wid(load_wid),
		.warp_pcs(warp_pcs),
		.thread_masks(thread_masks),
		.active_warps(active_warps)
	);

endmodule

// ==== test/simt_irq_sva.sv ====
/*
 * assertions on the thread transfer unit scheduler outputs
 * and the bind that attaches them to every transfer unit instance
 */
`timescale 1ns/1ps

module simt_irq_sva #(
	parameter int thread_cnt = 8
) (
	input logic clk,
	input logic reset,
	input simt_irq_pkg::irqc_state_t state,
	input logic swap_schedule_data,
	input logic paused,
	input logic [thread_cnt-1:0] load_tmask,
	input logic [thread_cnt-1:0] current_tmask
);

	// running count of assertion failures
	int fail_cnt = 0;

	// the warp table is only overwritten on the way into and out of the ISR, one cycle each time
	load_only_in_swap_or_revert: assert property (@(posedge clk) disable iff (reset)
		swap_schedule_data |->
		(state == simt_irq_pkg::irqc_pc_swap || state == simt_irq_pkg::irqc_revert_warp)
		##1 !swap_schedule_data)
	else begin
		$error("swap_schedule_data outside swap and revert or longer than one cycle");
		fail_cnt++;
	end

	// exactly one thread is handed to the ISR, and the target warp still owned it
	swap_mask_onehot: assert property (@(posedge clk) disable iff (reset)
		(state == simt_irq_pkg::irqc_pc_swap) |->
		($onehot(load_tmask) && (|(load_tmask & current_tmask))))
	else begin
		$error("load_tmask is not a one-hot thread of the target warp during the PC swap");
		fail_cnt++;
	end

	// the pause starts in the drained cycle before the swap and covers every load
	paused_during_load: assert property (@(posedge clk) disable iff (reset)
		swap_schedule_data |->
		(paused && (state != simt_irq_pkg::irqc_pc_swap || $past(paused))))
	else begin
		$error("scheduler not paused around a warp table load");
		fail_cnt++;
	end

endmodule

bind thread_transfer_unit simt_irq_sva #(
	.thread_cnt(thread_cnt)
) u_ttu_sva (
	.clk(clk),
	.reset(reset),
	.state(state),
	.swap_schedule_data(swap_schedule_data),
	.paused(paused),
	.load_tmask(load_tmask),
	.current_tmask(current_tmask)
);

// ==== test/simt_irq_tb.sv ====
/*
 * testbench for the SIMT interrupt path
 * clock and reset, AXI4-Lite master tasks, a pipeline model around the warp table,
 * the expected_revert reference, compare tasks and a watchdog
 */
`timescale 1ns/1ps

module simt_irq_tb;

	localparam int warp_cnt = 4;
	localparam int thread_cnt = 8;
	localparam int wid_w = $clog2(warp_cnt);
	localparam int mask_w = warp_cnt * thread_cnt;
	localparam int xlen = simt_irq_pkg::xlen;
	// register test, eight pulls from warp 3, six random targets, two misses
	localparam int scen_cnt = 17;
	localparam int seed = 98;

	localparam simt_irq_pkg::irq_status_t st_busy = '{not_found: 1'b0, done: 1'b0, busy: 1'b1};
	localparam simt_irq_pkg::irq_status_t st_done = '{not_found: 1'b0, done: 1'b1, busy: 1'b0};
	localparam simt_irq_pkg::irq_status_t st_miss = '{not_found: 1'b1, done: 1'b0, busy: 1'b0};

	// what the warp should look like once the ISR has returned
	typedef struct packed {
		logic [thread_cnt-1:0] tmask;
		logic [warp_cnt-1:0] wmask;
		logic [mask_w-1:0] ttu;
	} revert_t;

	logic clk;
	logic reset;
	simt_irq_pkg::axil_aw_t aw;
	simt_irq_pkg::axil_w_t w;
	simt_irq_pkg::axil_ar_t ar;
	logic bready;
	logic rready;
	logic no_pending_instr;
	logic [warp_cnt-1:0] barrier_stalls;
	logic [warp_cnt-1:0] ipdom_stack_empty;
	logic issue_valid;
	logic [wid_w-1:0] issue_wid;
	logic branch_valid;
	logic [wid_w-1:0] branch_wid;
	logic branch_taken;
	logic [xlen-1:0] branch_dest;
	simt_irq_pkg::axil_r_t r;
	simt_irq_pkg::axil_b_t b;
	simt_irq_pkg::axil_ready_t ready;
	logic [warp_cnt-1:0][xlen-1:0] warp_pcs;
	logic [warp_cnt-1:0][thread_cnt-1:0] thread_masks;
	logic [warp_cnt-1:0] active_warps;
	logic [warp_cnt-1:0][thread_cnt-1:0] ttu_tid_mask;
	logic paused;
	int errors;

	simt_irq_top #(
		.warp_cnt(warp_cnt),
		.thread_cnt(thread_cnt)
	) uut (
		.clk(clk),
		.reset(reset),
		.aw(aw),
		.w(w),
		.ar(ar),
		.bready(bready),
		.rready(rready),
		.no_pending_instr(no_pending_instr),
		.barrier_stalls(barrier_stalls),
		.ipdom_stack_empty(ipdom_stack_empty),
		.issue_valid(issue_valid),
		.issue_wid(issue_wid),
		.branch_valid(branch_valid),
		.branch_wid(branch_wid),
		.branch_taken(branch_taken),
		.branch_dest(branch_dest),
		.r(r),
		.b(b),
		.ready(ready),
		.warp_pcs(warp_pcs),
		.thread_masks(thread_masks),
		.active_warps(active_warps),
		.ttu_tid_mask(ttu_tid_mask),
		.paused(paused)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// the pulled thread leaves its warp, an emptied warp drops out of the active vector,
	// and the transfer record loses the bit of the pulled thread
	function automatic revert_t expected_revert(input logic [thread_cnt-1:0] tmask,
		input logic [warp_cnt-1:0] wmask, input logic [mask_w-1:0] ttu, input int wid,
		input int tid);
		revert_t res;
		res.tmask = tmask;
		res.tmask[tid] = 1'b0;
		res.wmask = wmask;
		if (res.tmask == '0)
			res.wmask[wid] = 1'b0;
		res.ttu = ttu;
		res.ttu[wid * thread_cnt + tid] = 1'b0;
		return res;
	endfunction

	task automatic word_check(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic mask_check(input string name, input logic [mask_w-1:0] got,
		input logic [mask_w-1:0] exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic status_check(input simt_irq_pkg::irq_status_t got,
		input simt_irq_pkg::irq_status_t exp);
		if (got !== exp) begin
			$display("error status got %h expected %h", got, exp);
			errors++;
		end
	endtask

	// all bus tasks start and end on a falling edge
	task automatic write_reg(input logic [simt_irq_pkg::axil_addr_w-1:0] addr,
		input logic [xlen-1:0] data);
		aw = '{valid: 1'b1, addr: addr};
		w = '{valid: 1'b1, data: data, strb: 4'hf};
		@(negedge clk);
		// ready high here means the next rising edge takes the write
		while (!ready.aw)
			@(negedge clk);
		@(negedge clk);
		aw.valid = 1'b0;
		w.valid = 1'b0;
		while (!b.valid)
			@(negedge clk);
		word_check("bresp", xlen'(b.resp), xlen'(simt_irq_pkg::axil_okay));
		@(negedge clk);
	endtask

	task automatic read_reg(input logic [simt_irq_pkg::axil_addr_w-1:0] addr,
		output logic [xlen-1:0] data);
		ar = '{valid: 1'b1, addr: addr};
		@(negedge clk);
		while (!ready.ar)
			@(negedge clk);
		@(negedge clk);
		ar.valid = 1'b0;
		while (!r.valid)
			@(negedge clk);
		data = r.data;
		word_check("rresp", xlen'(r.resp), xlen'(simt_irq_pkg::axil_okay));
		@(negedge clk);
	endtask

	task automatic wait_not_busy(output simt_irq_pkg::irq_status_t st);
		logic [xlen-1:0] rdata;
		do
			read_reg(simt_irq_pkg::reg_status, rdata);
		while (rdata[0]);
		st = simt_irq_pkg::irq_status_t'(rdata[2:0]);
	endtask

	// a few cycles of random issue and branch traffic so that PCs differ per warp
	task automatic pipeline_activity();
		repeat (4) begin
			issue_valid = 1'($urandom);
			issue_wid = wid_w'($urandom);
			branch_valid = 1'($urandom);
			branch_taken = 1'($urandom);
			branch_wid = wid_w'($urandom);
			branch_dest = $urandom & 32'hffff_fffc;
			@(negedge clk);
		end
		issue_valid = 1'b0;
		branch_valid = 1'b0;
		branch_taken = 1'b0;
	endtask

	task automatic run_irq(input int wid, input int tid, input bit gate);
		logic [warp_cnt-1:0][xlen-1:0] snap_pcs;
		logic [mask_w-1:0] snap_masks;
		logic [warp_cnt-1:0] snap_active;
		logic [mask_w-1:0] snap_ttu;
		logic [xlen-1:0] isr_pc;
		logic [xlen-1:0] rdata;
		simt_irq_pkg::irq_status_t st;
		revert_t exp;
		bit found;
		pipeline_activity();
		snap_pcs = warp_pcs;
		snap_masks = thread_masks;
		snap_active = active_warps;
		snap_ttu = ttu_tid_mask;
		isr_pc = $urandom & 32'hffff_fffc;
		// an inactive warp, a masked thread or one already handed over is a miss
		found = snap_active[wid] && snap_masks[wid * thread_cnt + tid] &&
			snap_ttu[wid * thread_cnt + tid];
		write_reg(simt_irq_pkg::reg_target, {16'(wid), 16'(tid)});
		write_reg(simt_irq_pkg::reg_isr_pc, isr_pc);
		no_pending_instr = !gate;
		write_reg(simt_irq_pkg::reg_ctrl, 32'h1);
		if (gate) begin
			// pending work, then a barrier stall, then a non-empty IPDOM stack
			for (int s = 0; s < 3; s++) begin
				no_pending_instr = (s != 0);
				barrier_stalls = (s == 1) ? warp_cnt'(1) : '0;
				ipdom_stack_empty = (s == 2) ? ~(warp_cnt'(1) << wid) : '1;
				repeat (6) @(negedge clk);
				read_reg(simt_irq_pkg::reg_status, rdata);
				status_check(simt_irq_pkg::irq_status_t'(rdata[2:0]), st_busy);
				word_check("warp_pcs", warp_pcs[wid], snap_pcs[wid]);
				// scheduling keeps running until the pipeline has drained
				mask_check("paused", mask_w'(paused), '0);
			end
			ipdom_stack_empty = '1;
		end
		if (found) begin
			while (uut.irqc_state != simt_irq_pkg::irqc_wait_isr)
				@(negedge clk);
			word_check("warp_pcs", warp_pcs[wid], isr_pc);
			mask_check("thread_masks", mask_w'(thread_masks[wid]), mask_w'(thread_cnt'(1) << tid));
			mask_check("active_warps", mask_w'(active_warps), mask_w'(warp_cnt'(1) << wid));
			// the ISR has to be scheduled, so the pause is over
			mask_check("paused", mask_w'(paused), '0);
			// the ISR returns by jumping back to its own entry
			branch_valid = 1'b1;
			branch_taken = 1'b1;
			branch_wid = wid_w'(wid);
			branch_dest = isr_pc;
			@(negedge clk);
			branch_valid = 1'b0;
			branch_taken = 1'b0;
			wait_not_busy(st);
			status_check(st, st_done);
			exp = expected_revert(snap_masks[wid * thread_cnt +: thread_cnt], snap_active,
				snap_ttu, wid, tid);
			word_check("warp_pcs", warp_pcs[wid], snap_pcs[wid]);
			mask_check("thread_masks", mask_w'(thread_masks[wid]), mask_w'(exp.tmask));
			mask_check("active_warps", mask_w'(active_warps), mask_w'(exp.wmask));
			mask_check("ttu_tid_mask", ttu_tid_mask, exp.ttu);
		end else begin
			wait_not_busy(st);
			status_check(st, st_miss);
			for (int i = 0; i < warp_cnt; i++)
				word_check("warp_pcs", warp_pcs[i], snap_pcs[i]);
			mask_check("thread_masks", thread_masks, snap_masks);
			mask_check("active_warps", mask_w'(active_warps), mask_w'(snap_active));
			mask_check("ttu_tid_mask", ttu_tid_mask, snap_ttu);
		end
	endtask

	// each scenario fits well inside 200 cycles
	initial begin
		repeat (scen_cnt * 200 + 16) @(posedge clk);
		$display("timeout, the interrupt sequence did not finish within %0d cycles",
			scen_cnt * 200);
		$display("%0d check errors, %0d assertion failures", errors,
			uut.u_thread_transfer_unit.u_ttu_sva.fail_cnt);
		$display("sim failed");
		$finish;
	end

	initial begin
		logic [xlen-1:0] rdata;
		logic [xlen-1:0] pc;
		int first_wid;
		int first_tid;
		int wid;
		int tid;
		void'($urandom(seed));
		errors = 0;
		aw = '0;
		w = '0;
		ar = '0;
		bready = 1'b1;
		rready = 1'b1;
		no_pending_instr = 1'b1;
		barrier_stalls = '0;
		ipdom_stack_empty = '1;
		issue_valid = 1'b0;
		issue_wid = '0;
		branch_valid = 1'b0;
		branch_wid = '0;
		branch_taken = 1'b0;
		branch_dest = '0;
		reset = 1'b1;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		// every warp starts active at PC 0 with all threads, and no thread is handed over
		for (int i = 0; i < warp_cnt; i++)
			word_check("warp_pcs", warp_pcs[i], '0);
		mask_check("thread_masks", thread_masks, '1);
		mask_check("active_warps", mask_w'(active_warps), mask_w'({warp_cnt{1'b1}}));
		mask_check("ttu_tid_mask", ttu_tid_mask, '1);
		mask_check("paused", mask_w'(paused), '0);
		// register access with STATUS clear after reset
		read_reg(simt_irq_pkg::reg_status, rdata);
		word_check("status", rdata, '0);
		pc = $urandom & 32'hffff_fffc;
		write_reg(simt_irq_pkg::reg_target, {16'd2, 16'd5});
		write_reg(simt_irq_pkg::reg_isr_pc, pc);
		read_reg(simt_irq_pkg::reg_target, rdata);
		word_check("target", rdata, {16'd2, 16'd5});
		read_reg(simt_irq_pkg::reg_isr_pc, rdata);
		word_check("isr_pc", rdata, pc);
		// warp 3 loses every thread, the first pull also walks through drain gating
		for (int t = 0; t < thread_cnt; t++)
			run_irq(3, t, t == 0);
		for (int n = 0; n < 6; n++) begin
			wid = $urandom % 3;
			tid = $urandom % thread_cnt;
			if (n == 0) begin
				first_wid = wid;
				first_tid = tid;
			end
			run_irq(wid, tid, 1'b0);
		end
		// an inactive warp and a thread that was already pulled
		run_irq(3, 2, 1'b0);
		run_irq(first_wid, first_tid, 1'b0);
		$display("%0d check errors, %0d assertion failures", errors,
			uut.u_thread_transfer_unit.u_ttu_sva.fail_cnt);
		if (errors == 0 && uut.u_thread_transfer_unit.u_ttu_sva.fail_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
common/simt_irq_pkg.sv
hdl/irq_controller.sv
hdl/thread_transfer_unit.sv
hdl/warp_table.sv
hdl/simt_irq_top.sv
test/simt_irq_sva.sv
test/simt_irq_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= simt_irq_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= sim passed

SRCS := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
